// ==== design/conv_ctrl_pkg.sv ====
// ====================================================================
// Control constants for the convolution row engine
// Kernel width, multiplier pipeline depth and the flag word layout
// ====================================================================

`default_nettype none

package conv_ctrl_pkg;

    // Horizontal kernel size, one accumulator column per tap
    localparam int KW = 3;

    // Enabled cycles from operand capture to product
    localparam int MUL_STAGES = 3;

    // Per-beat side-channel flags
    localparam int FLAGS_W = 3;
    typedef logic [FLAGS_W-1:0] flags_t;

    localparam int FLAG_FIRST = 0;
    localparam int FLAG_LAST  = 1;
    localparam int FLAG_RELU  = 2;

endpackage

`default_nettype wire

// ==== design/conv_data_pkg.sv ====
// ====================================================================
// Data widths and vector types for the convolution row engine
// Pixels, weights, products, bias, accumulators and outputs
// ====================================================================

`default_nettype none

package conv_data_pkg;

    localparam int PIXEL_W = 8;

    typedef logic signed [PIXEL_W-1:0] pixel_t;
    typedef logic signed [PIXEL_W-1:0] weight_t;

    // Column 0 weight sits in the low byte
    typedef logic [conv_ctrl_pkg::KW*PIXEL_W-1:0] weight_vec_t;

    localparam int PROD_W = 2 * PIXEL_W;
    typedef logic signed [PROD_W-1:0] prod_t;

    localparam int BIAS_W = 16;
    typedef logic signed [BIAS_W-1:0] bias_t;

    // Sums wrap silently at this width
    localparam int ACC_W = 24;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic signed [PIXEL_W-1:0] out_t;
    localparam int OUT_MAX = 127;
    localparam int OUT_MIN = -128;

endpackage

`default_nettype wire

// ==== design/delay_line.sv ====
// ====================================================================
// Clock-enabled delay line for beat valid, flags and bias
// Keeps side-channel data aligned with the multiplier output
// ====================================================================

`default_nettype none

module delay_line #(
    parameter int DEPTH = 1
) (
    input  logic                  aclk,
    input  logic                  aclken,
    input  logic                  arst_n,
    input  logic                  valid_in,
    input  conv_ctrl_pkg::flags_t flags_in,
    input  conv_data_pkg::bias_t  bias_in,
    output logic                  valid_out,
    output conv_ctrl_pkg::flags_t flags_out,
    output conv_data_pkg::bias_t  bias_out
);

    logic [DEPTH-1:0]      valid_q;
    conv_ctrl_pkg::flags_t flags_q [DEPTH];
    conv_data_pkg::bias_t  bias_q  [DEPTH];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (aclken) begin
            valid_q[0] <= valid_in;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Empty beats enter with cleared flags
    always_ff @(posedge aclk) begin
        if (aclken) begin
            flags_q[0] <= valid_in ? flags_in : '0;
            bias_q[0]  <= bias_in;
            for (int i = 1; i < DEPTH; i++) begin
                flags_q[i] <= flags_q[i-1];
                bias_q[i]  <= bias_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[DEPTH-1];
    assign flags_out = flags_q[DEPTH-1];
    assign bias_out  = bias_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/mult_pipe.sv ====
// ====================================================================
// Three-stage signed multiplier for one pixel and one weight
// Operand capture, multiply and product output registers
// ====================================================================

`default_nettype none

module mult_pipe (
    input  logic                   aclk,
    input  logic                   aclken,
    input  logic                   arst_n,
    input  conv_data_pkg::pixel_t  a,
    input  conv_data_pkg::weight_t b,
    output conv_data_pkg::prod_t   prod
);

    conv_data_pkg::pixel_t  a_q;
    conv_data_pkg::weight_t b_q;
    conv_data_pkg::prod_t   mid_q;
    conv_data_pkg::prod_t   prod_q;

    // Stage count here must match conv_ctrl_pkg::MUL_STAGES
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            a_q    <= '0;
            b_q    <= '0;
            mid_q  <= '0;
            prod_q <= '0;
        end else if (aclken) begin
            // Stage 1
            a_q    <= a;
            b_q    <= b;
            // Stage 2, both operands sign-extended to product width
            mid_q  <= conv_data_pkg::prod_t'(a_q) * conv_data_pkg::prod_t'(b_q);
            // Stage 3
            prod_q <= mid_q;
        end
    end

    assign prod = prod_q;

endmodule

`default_nettype wire

// ==== design/conv_column.sv ====
// ====================================================================
// Accumulator for a single kernel column
// Start-value select, running sum and completed-result register
// ====================================================================

`default_nettype none

module conv_column (
    input  logic                 aclk,
    input  logic                 aclken,
    input  logic                 arst_n,
    input  logic                 valid,
    input  logic                 first,
    input  logic                 last,
    input  conv_data_pkg::prod_t prod,
    input  conv_data_pkg::acc_t  start,
    output conv_data_pkg::acc_t  result,
    output logic                 done
);

    conv_data_pkg::acc_t acc_q;
    conv_data_pkg::acc_t base;
    conv_data_pkg::acc_t sum;

    // First beat of a block seeds from the start value
    always_comb begin
        base = first ? start : acc_q;
        sum  = base + conv_data_pkg::acc_t'(prod);
    end

    // Running sum over the beats of a block
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q <= '0;
        end else if (aclken && valid) begin
            acc_q <= sum;
        end
    end

    // Result stays put until the next block completes
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (aclken && valid && last) begin
            result <= sum;
        end
    end

    // One enabled cycle per completed block
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (aclken) begin
            done <= valid && last;
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_unit.sv ====
// ====================================================================
// Convolution unit with KW multiplier lanes and chained columns
// Bias and flags travel alongside the products through a delay line
// ====================================================================

`default_nettype none

module conv_unit (
    input  logic                       aclk,
    input  logic                       aclken,
    input  logic                       arst_n,
    input  logic                       s_valid,
    input  conv_data_pkg::pixel_t      s_pixel,
    input  conv_data_pkg::weight_vec_t s_weights,
    input  conv_data_pkg::bias_t       s_bias,
    input  conv_ctrl_pkg::flags_t      s_flags,
    output conv_data_pkg::acc_t        sum,
    output logic                       sum_valid,
    output logic                       sum_relu
);

    logic                  al_valid;
    conv_ctrl_pkg::flags_t al_flags;
    conv_data_pkg::bias_t  al_bias;

    conv_data_pkg::prod_t  prod       [conv_ctrl_pkg::KW];
    conv_data_pkg::acc_t   col_start  [conv_ctrl_pkg::KW];
    conv_data_pkg::acc_t   col_result [conv_ctrl_pkg::KW];
    logic [conv_ctrl_pkg::KW-1:0] col_done;

    // Side channel matched to the multiplier latency
    delay_line #(
        .DEPTH (conv_ctrl_pkg::MUL_STAGES)
    ) u_delay_line (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .valid_in  (s_valid),
        .flags_in  (s_flags),
        .bias_in   (s_bias),
        .valid_out (al_valid),
        .flags_out (al_flags),
        .bias_out  (al_bias)
    );

    for (genvar k = 0; k < conv_ctrl_pkg::KW; k++) begin : gen_col
        mult_pipe u_mult_pipe (
            .aclk   (aclk),
            .aclken (aclken),
            .arst_n (arst_n),
            .a      (s_pixel),
            .b      (conv_data_pkg::weight_t'(s_weights[k*conv_data_pkg::PIXEL_W +:
                                                        conv_data_pkg::PIXEL_W])),
            .prod   (prod[k])
        );

        // Column 0 seeds from bias, the rest from the previous column
        if (k == 0) begin : gen_seed_bias
            assign col_start[k] = conv_data_pkg::acc_t'(al_bias);
        end else begin : gen_seed_chain
            assign col_start[k] = col_result[k-1];
        end

        conv_column u_conv_column (
            .aclk   (aclk),
            .aclken (aclken),
            .arst_n (arst_n),
            .valid  (al_valid),
            .first  (al_flags[conv_ctrl_pkg::FLAG_FIRST]),
            .last   (al_flags[conv_ctrl_pkg::FLAG_LAST]),
            .prod   (prod[k]),
            .start  (col_start[k]),
            .result (col_result[k]),
            .done   (col_done[k])
        );
    end

    // Relu taken from the last beat, in step with the result register
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sum_relu <= 1'b0;
        end else if (aclken && al_valid && al_flags[conv_ctrl_pkg::FLAG_LAST]) begin
            sum_relu <= al_flags[conv_ctrl_pkg::FLAG_RELU];
        end
    end

    assign sum       = col_result[conv_ctrl_pkg::KW-1];
    assign sum_valid = col_done[conv_ctrl_pkg::KW-1];

endmodule

`default_nettype wire

// ==== design/out_activation.sv ====
// ====================================================================
// Output stage with optional ReLU and signed 8-bit saturation
// ====================================================================

`default_nettype none

module out_activation (
    input  logic                aclk,
    input  logic                aclken,
    input  logic                arst_n,
    input  conv_data_pkg::acc_t sum,
    input  logic                sum_valid,
    input  logic                relu,
    output logic                m_valid,
    output conv_data_pkg::out_t m_data
);

    conv_data_pkg::acc_t act;
    conv_data_pkg::out_t sat;

    always_comb begin
        // Negative sums drop to zero under ReLU
        act = (relu && sum[conv_data_pkg::ACC_W-1]) ? '0 : sum;
        if (act > conv_data_pkg::acc_t'(conv_data_pkg::OUT_MAX)) begin
            sat = conv_data_pkg::out_t'(conv_data_pkg::OUT_MAX);
        end else if (act < conv_data_pkg::acc_t'(conv_data_pkg::OUT_MIN)) begin
            sat = conv_data_pkg::out_t'(conv_data_pkg::OUT_MIN);
        end else begin
            sat = conv_data_pkg::out_t'(act);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (aclken) begin
            m_valid <= sum_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && sum_valid) begin
            m_data <= sat;
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_engine.sv ====
// ====================================================================
// Top level of the convolution row engine
// Convolution unit followed by the activation output stage
// ====================================================================

`default_nettype none

module conv_engine (
    input  logic                       aclk,
    input  logic                       aclken,
    input  logic                       arst_n,
    input  logic                       s_valid,
    input  conv_data_pkg::pixel_t      s_pixel,
    input  conv_data_pkg::weight_vec_t s_weights,
    input  conv_data_pkg::bias_t       s_bias,
    input  conv_ctrl_pkg::flags_t      s_flags,
    output logic                       m_valid,
    output conv_data_pkg::out_t        m_data
);

    conv_data_pkg::acc_t sum;
    logic                sum_valid;
    logic                sum_relu;

    conv_unit u_conv_unit (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .s_valid   (s_valid),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_bias    (s_bias),
        .s_flags   (s_flags),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_relu  (sum_relu)
    );

    out_activation u_out_activation (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .sum       (sum),
        .sum_valid (sum_valid),
        .relu      (sum_relu),
        .m_valid   (m_valid),
        .m_data    (m_data)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_conv_engine.sv ====
// ======================================================================
// Testbench for the convolution row engine
// Directed, random, ReLU, saturation, stall and mid-run reset blocks,
// chained-column reference model, compare process and cycle timeout
// ======================================================================

`default_nettype none

module tb_conv_engine;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF       = 4;
    localparam int MAX_LEN        = 8;
    localparam int RAND_BLOCKS    = 200;
    localparam int STALL_BLOCKS   = 100;
    localparam int DIRECTED_BEATS = 110;
    localparam int TOTAL_BEATS    = DIRECTED_BEATS + (RAND_BLOCKS + STALL_BLOCKS) * MAX_LEN;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    logic                       aclk = 1'b0;
    logic                       aclken;
    logic                       arst_n;
    logic                       s_valid;
    conv_data_pkg::pixel_t      s_pixel;
    conv_data_pkg::weight_vec_t s_weights;
    conv_data_pkg::bias_t       s_bias;
    conv_ctrl_pkg::flags_t      s_flags;
    logic                       m_valid;
    conv_data_pkg::out_t        m_data;

    integer seed = 32'h2f96bc98;
    int     cycle_count = 0;
    int     results_got = 0;
    int     blocks_expected = 0;
    logic   stall_on = 1'b0;

    conv_data_pkg::out_t        exp_q [$];
    conv_data_pkg::acc_t        ref_prev [conv_ctrl_pkg::KW];
    conv_data_pkg::pixel_t      blk_pix [MAX_LEN];
    conv_data_pkg::weight_vec_t blk_wts [MAX_LEN];

    conv_engine u_conv_engine (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .s_valid   (s_valid),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_bias    (s_bias),
        .s_flags   (s_flags),
        .m_valid   (m_valid),
        .m_data    (m_data)
    );

    always #CLK_HALF aclk = ~aclk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopping after first failure");
    endtask

    task automatic check_out(input conv_data_pkg::out_t got, input conv_data_pkg::out_t exp,
                             input string name);
        if (got !== exp) begin
            fail_run($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("%s count is %0d but %0d blocks were sent", what, got, exp));
        end
    endtask

    // Each column seeds from the previous column's result of the last block
    function automatic conv_data_pkg::out_t conv_ref(
        input conv_data_pkg::pixel_t      pix [MAX_LEN],
        input conv_data_pkg::weight_vec_t wts [MAX_LEN],
        input int                         len,
        input conv_data_pkg::bias_t       bias,
        input logic                       relu
    );
        conv_data_pkg::acc_t    new_res [conv_ctrl_pkg::KW];
        conv_data_pkg::weight_t w;
        int s;
        int v;
        for (int k = 0; k < conv_ctrl_pkg::KW; k++) begin
            s = (k == 0) ? int'(bias) : int'(ref_prev[k-1]);
            for (int b = 0; b < len; b++) begin
                w = conv_data_pkg::weight_t'(wts[b][k*conv_data_pkg::PIXEL_W +:
                                                    conv_data_pkg::PIXEL_W]);
                // Wrap at accumulator width after every beat
                s = int'(conv_data_pkg::acc_t'(s + int'(pix[b]) * int'(w)));
            end
            new_res[k] = conv_data_pkg::acc_t'(s);
        end
        ref_prev = new_res;
        v = int'(new_res[conv_ctrl_pkg::KW-1]);
        if (relu && v < 0) begin
            v = 0;
        end
        if (v > conv_data_pkg::OUT_MAX) begin
            v = conv_data_pkg::OUT_MAX;
        end else if (v < conv_data_pkg::OUT_MIN) begin
            v = conv_data_pkg::OUT_MIN;
        end
        return conv_data_pkg::out_t'(v);
    endfunction

    function automatic conv_data_pkg::weight_vec_t pack_weights(
        input conv_data_pkg::weight_t w0,
        input conv_data_pkg::weight_t w1,
        input conv_data_pkg::weight_t w2
    );
        return {w2, w1, w0};
    endfunction

    task automatic step_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic pick_enable();
        if (stall_on) begin
            aclken = ($unsigned($random(seed)) % 100) >= 30;
        end else begin
            aclken = 1'b1;
        end
    endtask

    // Holds the beat until an enabled edge takes it
    task automatic drive_beat(input conv_data_pkg::pixel_t pix,
                              input conv_data_pkg::weight_vec_t wts,
                              input conv_data_pkg::bias_t bias,
                              input conv_ctrl_pkg::flags_t flags);
        s_valid   = 1'b1;
        s_pixel   = pix;
        s_weights = wts;
        s_bias    = bias;
        s_flags   = flags;
        pick_enable();
        while (!aclken) begin
            step_cycle();
            pick_enable();
        end
        step_cycle();
        s_valid = 1'b0;
    endtask

    task automatic send_block(input int len, input conv_data_pkg::bias_t bias, input logic relu);
        conv_ctrl_pkg::flags_t flags;
        for (int b = 0; b < len; b++) begin
            flags = '0;
            flags[conv_ctrl_pkg::FLAG_FIRST] = (b == 0);
            flags[conv_ctrl_pkg::FLAG_LAST]  = (b == len - 1);
            flags[conv_ctrl_pkg::FLAG_RELU]  = relu;
            drive_beat(blk_pix[b], blk_wts[b], bias, flags);
        end
        exp_q.push_back(conv_ref(blk_pix, blk_wts, len, bias, relu));
        blocks_expected++;
    endtask

    task automatic send_single(input conv_data_pkg::pixel_t pix,
                               input conv_data_pkg::weight_vec_t wts,
                               input conv_data_pkg::bias_t bias);
        blk_pix[0] = pix;
        blk_wts[0] = wts;
        send_block(1, bias, 1'b0);
    endtask

    task automatic fill_const(input int len, input conv_data_pkg::pixel_t pix,
                              input conv_data_pkg::weight_vec_t wts);
        for (int b = 0; b < len; b++) begin
            blk_pix[b] = pix;
            blk_wts[b] = wts;
        end
    endtask

    task automatic random_blocks(input int count, input logic stall);
        int len;
        stall_on = stall;
        for (int i = 0; i < count; i++) begin
            len = 1 + int'($unsigned($random(seed)) % MAX_LEN);
            for (int b = 0; b < len; b++) begin
                blk_pix[b] = conv_data_pkg::pixel_t'($random(seed));
                blk_wts[b] = conv_data_pkg::weight_vec_t'($random(seed));
            end
            send_block(len, conv_data_pkg::bias_t'($random(seed)), ($random(seed) % 2) != 0);
        end
        stall_on = 1'b0;
    endtask

    // Blocks still in flight are lost with the pipeline contents
    task automatic apply_reset();
        arst_n  = 1'b0;
        s_valid = 1'b0;
        aclken  = 1'b1;
        blocks_expected -= exp_q.size();
        exp_q.delete();
        for (int k = 0; k < conv_ctrl_pkg::KW; k++) begin
            ref_prev[k] = '0;
        end
        repeat (5) step_cycle();
        arst_n = 1'b1;
    endtask

    // Pending results are due within the pipeline latency of the last beat
    task automatic drain();
        int waited;
        s_valid = 1'b0;
        aclken  = 1'b1;
        waited  = 0;
        while (exp_q.size() != 0 && waited < conv_ctrl_pkg::MUL_STAGES + 3) begin
            step_cycle();
            waited++;
        end
        repeat (conv_ctrl_pkg::MUL_STAGES + 2) step_cycle();
    endtask

    // Outputs and the aclken of the coming edge are both settled at the falling edge
    always @(negedge aclk) begin
        if (!arst_n) begin
            check_valid(m_valid, 1'b0, "m_valid");
        end else if (aclken && m_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("a result appeared while no block was pending");
            end else begin
                check_out(m_data, exp_q.pop_front(), "m_data");
                results_got++;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run("simulation timed out before all blocks produced a result");
        end
    end

    initial begin
        aclken    = 1'b1;
        arst_n    = 1'b0;
        s_valid   = 1'b0;
        s_pixel   = '0;
        s_weights = '0;
        s_bias    = '0;
        s_flags   = '0;
        apply_reset();

        // Single-beat chain after reset
        send_single(8'sd3, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd10);
        send_single(8'sd5, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd20);
        send_single(8'sd7, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd30);
        send_single(-8'sd2, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd40);
        send_single(8'sd4, pack_weights(8'sd2, -8'sd1, 8'sd3), -16'sd50);
        drain();

        // ReLU set, then the same negative sums with ReLU clear
        for (int r = 1; r >= 0; r--) begin
            fill_const(1, -8'sd2, pack_weights(8'sd1, 8'sd1, 8'sd1));
            repeat (3) send_block(1, -16'sd5, r != 0);
            fill_const(4, -8'sd100, pack_weights(8'sd100, 8'sd100, 8'sd100));
            repeat (2) send_block(4, -16'sd300, r != 0);
        end
        drain();

        // Saturation at both limits
        fill_const(4, 8'sd127, pack_weights(8'sd127, 8'sd127, 8'sd127));
        repeat (2) send_block(4, 16'sh7fff, 1'b0);
        fill_const(4, -8'sd128, pack_weights(8'sd127, 8'sd127, 8'sd127));
        repeat (3) send_block(4, 16'sh8000, 1'b0);
        drain();

        random_blocks(RAND_BLOCKS, 1'b0);
        drain();
        random_blocks(STALL_BLOCKS, 1'b1);
        drain();

        // Reset while results are in flight and restart the chain from zero
        random_blocks(6, 1'b0);
        // Back-to-back single beats keep m_valid high into the reset
        repeat (conv_ctrl_pkg::MUL_STAGES + 3) begin
            send_single(8'sd9, pack_weights(8'sd4, 8'sd5, -8'sd6), 16'sd60);
        end
        apply_reset();
        send_single(8'sd3, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd10);
        send_single(8'sd5, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd20);
        send_single(8'sd7, pack_weights(8'sd2, -8'sd1, 8'sd3), 16'sd30);
        drain();

        check_count(results_got, blocks_expected, "result");
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("expected results were still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== conv_engine.f ====
design/conv_ctrl_pkg.sv
design/conv_data_pkg.sv
design/delay_line.sv
design/mult_pipe.sv
design/conv_column.sv
design/conv_unit.sv
design/out_activation.sv
design/conv_engine.sv
testbench/tb_conv_engine.sv

// ==== Makefile ====
# Verilator build and run for the convolution row engine

VERILATOR  ?= verilator
TOP        ?= tb_conv_engine
RTL_TOP    ?= conv_engine
FILELIST   ?= conv_engine.f
BUILD_DIR  ?= obj_dir
EXE        ?= V$(TOP)
COMMON     ?= --timing --timescale 1ns/1ps
BUILD_OPTS ?= --binary -j 0
LINT_OPTS  ?= -Wall
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_OPTS) $(COMMON) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(EXE)

run: build
	./$(BUILD_DIR)/$(EXE) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only $(LINT_OPTS) $(COMMON) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
